/* noc_params.sv */
package noc_params;

    // Virtual channels per link
    localparam int VC_NUM = 2;

    // Width of a VC id
    localparam int VC_SIZE = $clog2(VC_NUM);

    // Flit payload width
    localparam int FLIT_DATA_SIZE = 16;

    // Flit kinds inside a wormhole packet
    typedef enum logic [1:0] {
        HEAD,
        BODY,
        TAIL
    } flit_label_t;

    // Head flit carries destination in the low data bits
    // x in the lowest coordinate field, y right above it
    typedef struct packed {
        flit_label_t               flit_label;
        logic [VC_SIZE-1:0]        vc_id;
        logic [FLIT_DATA_SIZE-1:0] data;
    } flit_t;

endpackage

/* mesh_params.sv */
package mesh_params;

    // Width of one mesh coordinate
    localparam int COORD_SIZE = 3;

    // Output ports of a mesh router
    // LOCAL goes to the attached node
    // NORTH is increasing y, EAST is increasing x
    typedef enum logic [2:0] {
        LOCAL,
        NORTH,
        SOUTH,
        EAST,
        WEST
    } port_t;

endpackage

/* circular_buffer.sv */
`timescale 1ns/1ps

module circular_buffer #(
    parameter int BUFFER_SIZE    = 8,
    parameter int PIPELINE_DEPTH = 5
)(
    input  noc_params::flit_t data_i,
    input  logic              read_i,
    input  logic              write_i,
    input  logic              clk,
    input  logic              rst,
    output noc_params::flit_t data_o,
    output logic              is_full_o,
    output logic              is_empty_o,
    output logic              on_off_o
);

    import noc_params::*;

    localparam int PTR_W = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(BUFFER_SIZE - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(BUFFER_SIZE);
    // Highest occupancy that still leaves PIPELINE_DEPTH free slots
    localparam logic [CNT_W-1:0] ON_LIMIT = CNT_W'(BUFFER_SIZE - PIPELINE_DEPTH);

    flit_t            mem [BUFFER_SIZE];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_write;
    logic             do_read;

    assign is_full_o  = (count == FULL_CNT);
    assign is_empty_o = (count == '0);

    // Write when full and read when empty are dropped
    assign do_write = write_i & ~is_full_o;
    assign do_read  = read_i & ~is_empty_o;

    // Oldest flit visible without a read
    assign data_o   = mem[rd_ptr];
    assign on_off_o = (count <= ON_LIMIT);

    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_write)
            begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read)
            begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // Occupancy unchanged on simultaneous read and write
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* input_buffer.sv */
`timescale 1ns/1ps

module input_buffer #(
    parameter int BUFFER_SIZE    = 8,
    parameter int PIPELINE_DEPTH = 5
)(
    input  noc_params::flit_t                 data_i,
    input  logic                              write_i,
    input  logic                              read_i,
    input  logic [noc_params::VC_SIZE-1:0]    vc_new_i,
    input  logic                              vc_valid_i,
    input  mesh_params::port_t                out_port_i,
    input  logic                              clk,
    input  logic                              rst,
    output noc_params::flit_t                 data_o,
    output logic                              is_full_o,
    output logic                              is_empty_o,
    output logic                              on_off_o,
    output logic                              va_req_o,
    output logic                              sa_ready_o,
    output mesh_params::port_t                out_port_o
);

    import noc_params::*;
    import mesh_params::*;

    typedef enum logic [1:0] {IDLE, VA, SA} state_t;

    state_t             state;
    state_t             state_next;
    port_t              out_port_next;
    logic [VC_SIZE-1:0] downstream_vc;
    logic [VC_SIZE-1:0] downstream_vc_next;
    logic               end_packet;
    logic               end_packet_next;
    logic               write_cmd;
    logic               read_cmd;
    logic               body_or_tail;
    flit_t              read_flit;

    circular_buffer #(
        .BUFFER_SIZE    (BUFFER_SIZE),
        .PIPELINE_DEPTH (PIPELINE_DEPTH)
    ) u_circular_buffer (
        .data_i     (data_i),
        .read_i     (read_cmd),
        .write_i    (write_cmd),
        .clk        (clk),
        .rst        (rst),
        .data_o     (read_flit),
        .is_full_o  (is_full_o),
        .is_empty_o (is_empty_o),
        .on_off_o   (on_off_o)
    );

    // Outgoing flit keeps label and data, vc_id is the downstream VC
    always_comb
    begin
        data_o            = read_flit;
        data_o.vc_id      = downstream_vc;
    end

    assign va_req_o     = (state == VA);
    assign sa_ready_o   = (state == SA) & ~is_empty_o;
    assign body_or_tail = (data_i.flit_label == BODY) | (data_i.flit_label == TAIL);

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            state         <= IDLE;
            out_port_o    <= LOCAL;
            downstream_vc <= '0;
            end_packet    <= 1'b0;
        end
        else
        begin
            state         <= state_next;
            out_port_o    <= out_port_next;
            downstream_vc <= downstream_vc_next;
            end_packet    <= end_packet_next;
        end
    end

    always_comb
    begin
        state_next         = state;
        out_port_next      = out_port_o;
        downstream_vc_next = downstream_vc;
        end_packet_next    = end_packet;
        write_cmd          = 1'b0;
        read_cmd           = 1'b0;
        case (state)
            IDLE:
            begin
                // New packet only into an empty FIFO, route latched here
                if (write_i && data_i.flit_label == HEAD && is_empty_o)
                begin
                    write_cmd     = 1'b1;
                    out_port_next = out_port_i;
                    state_next    = VA;
                end
            end
            VA, SA:
            begin
                // Body and tail accepted until the tail is in
                if (write_i && body_or_tail && !end_packet)
                begin
                    write_cmd = 1'b1;
                    if (data_i.flit_label == TAIL)
                    begin
                        end_packet_next = 1'b1;
                    end
                end
                if (state == VA && vc_valid_i)
                begin
                    downstream_vc_next = vc_new_i;
                    state_next         = SA;
                end
                if (state == SA && read_i)
                begin
                    read_cmd = 1'b1;
                    // Tail leaving ends the packet
                    if (read_flit.flit_label == TAIL && !is_empty_o)
                    begin
                        state_next      = IDLE;
                        end_packet_next = 1'b0;
                    end
                end
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

/* vc_allocator.sv */
`timescale 1ns/1ps

module vc_allocator (
    input  logic [noc_params::VC_NUM-1:0]  va_req_i,
    input  logic [noc_params::VC_NUM-1:0]  vc_release_i,
    input  logic                           clk,
    input  logic                           rst,
    output logic [noc_params::VC_NUM-1:0]  vc_grant_o,
    output logic [noc_params::VC_SIZE-1:0] vc_new_o
);

    import noc_params::*;

    localparam logic [VC_SIZE-1:0] LAST_VC = VC_SIZE'(VC_NUM - 1);

    // One busy bit per downstream VC
    logic [VC_NUM-1:0]  busy;
    logic [VC_SIZE-1:0] rr_ptr;
    logic [VC_SIZE-1:0] req_sel;
    logic [VC_SIZE-1:0] free_sel;
    logic               req_found;
    logic               free_found;
    logic               grant;

    // Round-robin search over requesters starting at rr_ptr
    always_comb
    begin
        int idx;
        req_found = 1'b0;
        req_sel   = '0;
        for (int i = 0; i < VC_NUM; i++)
        begin
            idx = (int'(rr_ptr) + i) % VC_NUM;
            if (!req_found && va_req_i[idx])
            begin
                req_found = 1'b1;
                req_sel   = VC_SIZE'(idx);
            end
        end
    end

    // Lowest free downstream VC, so scan from the top down
    always_comb
    begin
        free_found = 1'b0;
        free_sel   = '0;
        for (int i = VC_NUM - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                free_found = 1'b1;
                free_sel   = VC_SIZE'(i);
            end
        end
    end

    assign grant    = req_found & free_found;
    assign vc_new_o = free_sel;

    always_comb
    begin
        vc_grant_o          = '0;
        vc_grant_o[req_sel] = grant;
    end

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            busy   <= '0;
            rr_ptr <= '0;
        end
        else
        begin
            busy <= busy & ~vc_release_i;
            if (grant)
            begin
                busy[free_sel] <= 1'b1;
                // Winner goes to the back of the queue
                rr_ptr <= (req_sel == LAST_VC) ? '0 : req_sel + 1'b1;
            end
        end
    end

endmodule

/* input_port.sv */
`timescale 1ns/1ps

module input_port #(
    parameter int BUFFER_SIZE    = 8,
    parameter int PIPELINE_DEPTH = 5,
    parameter int X_CURRENT      = 0,
    parameter int Y_CURRENT      = 0
)(
    input  noc_params::flit_t              data_i,
    input  logic                           valid_i,
    input  logic [noc_params::VC_NUM-1:0]  vc_grant_i,
    input  logic [noc_params::VC_SIZE-1:0] vc_new_i,
    input  logic                           clk,
    input  logic                           rst,
    output noc_params::flit_t              flit_o,
    output logic                           valid_o,
    output mesh_params::port_t             out_port_o,
    output logic [noc_params::VC_NUM-1:0]  on_off_o,
    output logic [noc_params::VC_NUM-1:0]  va_req_o
);

    import noc_params::*;
    import mesh_params::*;

    localparam logic [COORD_SIZE-1:0] X_CUR   = COORD_SIZE'(X_CURRENT);
    localparam logic [COORD_SIZE-1:0] Y_CUR   = COORD_SIZE'(Y_CURRENT);
    localparam logic [VC_SIZE-1:0]    LAST_VC = VC_SIZE'(VC_NUM - 1);

    logic [COORD_SIZE-1:0] x_dest;
    logic [COORD_SIZE-1:0] y_dest;
    port_t                 route;
    logic [VC_NUM-1:0]     write_vc;
    logic [VC_NUM-1:0]     read_vc;
    logic [VC_NUM-1:0]     is_full;
    logic [VC_NUM-1:0]     sa_ready;
    flit_t                 buf_flit [VC_NUM];
    port_t                 buf_port [VC_NUM];
    logic [VC_SIZE-1:0]    rr_ptr;
    logic [VC_SIZE-1:0]    sel;
    logic                  sel_found;

    // Destination fields of a head flit
    assign x_dest = data_i.data[COORD_SIZE-1:0];
    assign y_dest = data_i.data[2*COORD_SIZE-1:COORD_SIZE];

    // XY routing, x dimension resolved first
    always_comb
    begin
        if (x_dest > X_CUR)
            route = EAST;
        else if (x_dest < X_CUR)
            route = WEST;
        else if (y_dest > Y_CUR)
            route = NORTH;
        else if (y_dest < Y_CUR)
            route = SOUTH;
        else
            route = LOCAL;
    end

    // VC demux of the incoming flit
    always_comb
    begin
        for (int v = 0; v < VC_NUM; v++)
        begin
            write_vc[v] = valid_i & (data_i.vc_id == VC_SIZE'(v));
        end
    end

    for (genvar v = 0; v < VC_NUM; v++)
    begin : gen_vc
        input_buffer #(
            .BUFFER_SIZE    (BUFFER_SIZE),
            .PIPELINE_DEPTH (PIPELINE_DEPTH)
        ) u_input_buffer (
            .data_i     (data_i),
            .write_i    (write_vc[v]),
            .read_i     (read_vc[v]),
            .vc_new_i   (vc_new_i),
            .vc_valid_i (vc_grant_i[v]),
            .out_port_i (route),
            .clk        (clk),
            .rst        (rst),
            .data_o     (buf_flit[v]),
            .is_full_o  (is_full[v]),
            .is_empty_o (),
            .on_off_o   (on_off_o[v]),
            .va_req_o   (va_req_o[v]),
            .sa_ready_o (sa_ready[v]),
            .out_port_o (buf_port[v])
        );
    end

    // Round-robin read arbiter over ready VCs
    always_comb
    begin
        int idx;
        sel_found = 1'b0;
        sel       = '0;
        for (int i = 0; i < VC_NUM; i++)
        begin
            idx = (int'(rr_ptr) + i) % VC_NUM;
            if (!sel_found && sa_ready[idx])
            begin
                sel_found = 1'b1;
                sel       = VC_SIZE'(idx);
            end
        end
        read_vc      = '0;
        read_vc[sel] = sel_found;
    end

    // Selected head flit leaves in the same cycle
    assign flit_o     = buf_flit[sel];
    assign out_port_o = buf_port[sel];
    assign valid_o    = sel_found;

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
            rr_ptr <= '0;
        else if (sel_found)
            rr_ptr <= (sel == LAST_VC) ? '0 : sel + 1'b1;
    end

endmodule

/* router_input_unit.sv */
`timescale 1ns/1ps

module router_input_unit #(
    parameter int BUFFER_SIZE    = 8,
    parameter int PIPELINE_DEPTH = 5,
    parameter int X_CURRENT      = 0,
    parameter int Y_CURRENT      = 0
)(
    input  noc_params::flit_t             data_i,
    input  logic                          valid_i,
    input  logic [noc_params::VC_NUM-1:0] vc_release_i,
    input  logic                          clk,
    input  logic                          rst,
    output noc_params::flit_t             flit_o,
    output logic                          valid_o,
    output mesh_params::port_t            out_port_o,
    output logic [noc_params::VC_NUM-1:0] on_off_o
);

    import noc_params::*;

    // VC allocation handshake
    logic [VC_NUM-1:0]  va_req;
    logic [VC_NUM-1:0]  vc_grant;
    logic [VC_SIZE-1:0] vc_new;

    input_port #(
        .BUFFER_SIZE    (BUFFER_SIZE),
        .PIPELINE_DEPTH (PIPELINE_DEPTH),
        .X_CURRENT      (X_CURRENT),
        .Y_CURRENT      (Y_CURRENT)
    ) u_input_port (
        .data_i     (data_i),
        .valid_i    (valid_i),
        .vc_grant_i (vc_grant),
        .vc_new_i   (vc_new),
        .clk        (clk),
        .rst        (rst),
        .flit_o     (flit_o),
        .valid_o    (valid_o),
        .out_port_o (out_port_o),
        .on_off_o   (on_off_o),
        .va_req_o   (va_req)
    );

    vc_allocator u_vc_allocator (
        .va_req_i     (va_req),
        .vc_release_i (vc_release_i),
        .clk          (clk),
        .rst          (rst),
        .vc_grant_o   (vc_grant),
        .vc_new_o     (vc_new)
    );

endmodule

/* router_input_unit_chk.sv */
`timescale 1ns/1ps

module router_input_unit_chk (
    input logic                          clk,
    input logic                          rst,
    input logic [noc_params::VC_NUM-1:0] read_vc_i,
    input logic [noc_params::VC_NUM-1:0] write_vc_i,
    input logic [noc_params::VC_NUM-1:0] is_full_i,
    input logic [noc_params::VC_NUM-1:0] sa_ready_i,
    input logic                          valid_i,
    input noc_params::flit_t             flit_i
);

    import noc_params::*;

    // Arbiter reads one VC per cycle at most
    a_one_read: assert property (@(posedge clk) disable iff (rst) $onehot0(read_vc_i))
        else $error("more than one VC read in one cycle");

    // A VC just read gives way to any other VC that was ready with it
    a_rr_yield: assert property (@(posedge clk) disable iff (rst)
        (read_vc_i != '0) && ((sa_ready_i & ~read_vc_i) != '0)
        |=> ((read_vc_i & $past(read_vc_i)) == '0))
        else $error("read arbiter served the same VC twice while another was ready");

    // Upstream must respect on/off before the FIFO fills
    a_no_full_write: assert property (@(posedge clk) disable iff (rst)
        (write_vc_i & is_full_i) == '0)
        else $error("write strobe to a full VC buffer");

    a_label_legal: assert property (@(posedge clk) disable iff (rst)
        valid_i |-> (flit_i.flit_label == HEAD || flit_i.flit_label == BODY ||
                     flit_i.flit_label == TAIL))
        else $error("output flit with an undefined label");

endmodule

bind input_port router_input_unit_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .read_vc_i  (read_vc),
    .write_vc_i (write_vc),
    .is_full_i  (is_full),
    .sa_ready_i (sa_ready),
    .valid_i    (valid_o),
    .flit_i     (flit_o)
);

/* tb_router_input_unit.sv */
`timescale 1ns/1ps

module tb_router_input_unit;

    import noc_params::*;
    import mesh_params::*;

    localparam int BUFFER_SIZE    = 8;
    localparam int PIPELINE_DEPTH = 5;
    localparam int TIMEOUT        = 200;

    logic              clk;
    logic              rst;
    flit_t             data_i;
    logic              valid_i;
    logic [VC_NUM-1:0] vc_release_i;
    flit_t             flit_o;
    logic              valid_o;
    port_t             out_port_o;
    logic [VC_NUM-1:0] on_off_o;

    int          errors;
    logic [31:0] lcg_state;

    // Observed outputs and the expected flits, split by downstream VC
    flit_t out_flit_q [$];
    port_t out_port_q [$];
    flit_t exp0_flit_q [$];
    port_t exp0_port_q [$];
    flit_t exp1_flit_q [$];
    port_t exp1_port_q [$];

    router_input_unit #(
        .BUFFER_SIZE    (BUFFER_SIZE),
        .PIPELINE_DEPTH (PIPELINE_DEPTH),
        .X_CURRENT      (2),
        .Y_CURRENT      (2)
    ) dut (
        .data_i       (data_i),
        .valid_i      (valid_i),
        .vc_release_i (vc_release_i),
        .clk          (clk),
        .rst          (rst),
        .flit_o       (flit_o),
        .valid_o      (valid_o),
        .out_port_o   (out_port_o),
        .on_off_o     (on_off_o)
    );

    always #4 clk = ~clk;

    // Outputs come from registered state, so the falling edge is a stable point
    always @(negedge clk)
    begin
        if (!rst && valid_o)
        begin
            out_flit_q.push_back(flit_o);
            out_port_q.push_back(out_port_o);
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [FLIT_DATA_SIZE-1:0] rand_data();
        logic [31:0] r;
        r = next_rand();
        return r[FLIT_DATA_SIZE-1:0];
    endfunction

    // Destination x in the low field, y above it, random upper bits
    function automatic logic [FLIT_DATA_SIZE-1:0] head_data(input int x, input int y);
        logic [31:0] r;
        r = next_rand();
        return {r[FLIT_DATA_SIZE-1:2*COORD_SIZE], COORD_SIZE'(y), COORD_SIZE'(x)};
    endfunction

    function automatic flit_t make_flit(input flit_label_t label, input int vc,
                                        input logic [FLIT_DATA_SIZE-1:0] data);
        flit_t f;
        f.flit_label = label;
        f.vc_id      = VC_SIZE'(vc);
        f.data       = data;
        return f;
    endfunction

    task automatic check_flit(input string name, input flit_t exp, input flit_t act);
        if (exp !== act)
        begin
            $display("ERROR %s: expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_port(input string name, input port_t exp, input port_t act);
        if (exp !== act)
        begin
            $display("ERROR %s: expected port %s actual %s", name, exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("ERROR %s: expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic send_flit(input flit_t f);
        @(negedge clk);
        data_i  = f;
        valid_i = 1'b1;
    endtask

    task automatic stop_send();
        @(negedge clk);
        valid_i = 1'b0;
    endtask

    // One-cycle release strobe from the downstream router
    task automatic release_vc(input int mask);
        @(negedge clk);
        vc_release_i = VC_NUM'(mask);
        @(negedge clk);
        vc_release_i = '0;
    endtask

    // Leaves the router with the downstream VC in vc_id
    task automatic expect_flit(input flit_t f, input int dvc, input port_t port);
        flit_t fwd;
        fwd       = f;
        fwd.vc_id = VC_SIZE'(dvc);
        if (dvc == 0)
        begin
            exp0_flit_q.push_back(fwd);
            exp0_port_q.push_back(port);
        end
        else
        begin
            exp1_flit_q.push_back(fwd);
            exp1_port_q.push_back(port);
        end
    endtask

    task automatic send_packet(input int vc, input int x, input int y, input int nbody,
                               input int dvc, input port_t port);
        flit_t f;
        f = make_flit(HEAD, vc, head_data(x, y));
        send_flit(f);
        expect_flit(f, dvc, port);
        for (int i = 0; i < nbody; i++)
        begin
            f = make_flit(BODY, vc, rand_data());
            send_flit(f);
            expect_flit(f, dvc, port);
        end
        f = make_flit(TAIL, vc, rand_data());
        send_flit(f);
        expect_flit(f, dvc, port);
        stop_send();
    endtask

    task automatic wait_outputs(input string name, input int n);
        int cycles;
        cycles = 0;
        while (out_flit_q.size() < n && cycles < TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (out_flit_q.size() < n)
        begin
            $display("%s: timed out waiting for %0d output flits, only %0d came out",
                     name, n, out_flit_q.size());
            errors++;
        end
    endtask

    task automatic compare_outputs(input string name);
        int    total;
        logic  have_exp;
        flit_t act;
        port_t act_port;
        flit_t exp;
        port_t exp_port;
        total = exp0_flit_q.size() + exp1_flit_q.size();
        wait_outputs(name, total);
        // Short quiet window so extra flits show up too
        repeat (4) @(posedge clk);
        if (out_flit_q.size() != total)
        begin
            $display("ERROR %s: expected %0d flits actual %0d", name, total, out_flit_q.size());
            errors++;
        end
        while (out_flit_q.size() > 0)
        begin
            act      = out_flit_q.pop_front();
            act_port = out_port_q.pop_front();
            have_exp = 1'b0;
            if (act.vc_id == '0 && exp0_flit_q.size() > 0)
            begin
                exp      = exp0_flit_q.pop_front();
                exp_port = exp0_port_q.pop_front();
                have_exp = 1'b1;
            end
            else if (act.vc_id != '0 && exp1_flit_q.size() > 0)
            begin
                exp      = exp1_flit_q.pop_front();
                exp_port = exp1_port_q.pop_front();
                have_exp = 1'b1;
            end
            if (have_exp)
            begin
                check_flit(name, exp, act);
                check_port(name, exp_port, act_port);
            end
            else
            begin
                $display("%s: flit on downstream VC %0d that no packet expects",
                         name, act.vc_id);
                errors++;
            end
        end
        exp0_flit_q.delete();
        exp0_port_q.delete();
        exp1_flit_q.delete();
        exp1_port_q.delete();
    endtask

    task automatic reset_values();
        check_bit("reset_valid", 1'b0, valid_o);
        for (int v = 0; v < VC_NUM; v++)
        begin
            check_bit("reset_on_off", 1'b1, on_off_o[v]);
        end
    endtask

    task automatic single_packet();
        send_packet(0, 4, 2, 2, 0, EAST);
        compare_outputs("single_packet");
        release_vc(1);
    endtask

    task automatic route_all_ports();
        send_packet(0, 2, 2, 1, 0, LOCAL);
        compare_outputs("route_local");
        release_vc(1);
        send_packet(0, 0, 2, 1, 0, WEST);
        compare_outputs("route_west");
        release_vc(1);
        send_packet(0, 2, 4, 1, 0, NORTH);
        compare_outputs("route_north");
        release_vc(1);
        send_packet(0, 2, 0, 1, 0, SOUTH);
        compare_outputs("route_south");
        release_vc(1);
    endtask

    task automatic interleave_packets();
        flit_t a [3];
        flit_t b [3];
        a[0] = make_flit(HEAD, 0, head_data(3, 2));
        a[1] = make_flit(BODY, 0, rand_data());
        a[2] = make_flit(TAIL, 0, rand_data());
        b[0] = make_flit(HEAD, 1, head_data(2, 1));
        b[1] = make_flit(BODY, 1, rand_data());
        b[2] = make_flit(TAIL, 1, rand_data());
        // Body into an idle VC is dropped
        send_flit(make_flit(BODY, 1, rand_data()));
        // VC 0 requests first and gets downstream VC 0
        for (int i = 0; i < 3; i++)
        begin
            send_flit(a[i]);
            expect_flit(a[i], 0, EAST);
            send_flit(b[i]);
            expect_flit(b[i], 1, SOUTH);
            // Undefined label in the middle of a packet is dropped
            if (i == 1)
            begin
                send_flit(flit_t'({2'b11, VC_SIZE'(0), rand_data()}));
            end
        end
        // Nothing after a tail belongs to the packet
        send_flit(make_flit(BODY, 0, rand_data()));
        send_flit(make_flit(TAIL, 1, rand_data()));
        stop_send();
        compare_outputs("interleave");
        release_vc(3);
    endtask

    task automatic on_off_flow();
        flit_t f;
        int    count;
        // Both downstream VCs stay held
        send_packet(0, 2, 2, 0, 0, LOCAL);
        send_packet(1, 2, 2, 0, 1, LOCAL);
        compare_outputs("on_off_hold");
        count = 0;
        for (int i = 0; i < BUFFER_SIZE; i++)
        begin
            if (i == 0)
                f = make_flit(HEAD, 0, head_data(5, 5));
            else if (i == BUFFER_SIZE - 1)
                f = make_flit(TAIL, 0, rand_data());
            else
                f = make_flit(BODY, 0, rand_data());
            send_flit(f);
            expect_flit(f, 0, EAST);
            stop_send();
            count++;
            check_bit("on_off_fill", (BUFFER_SIZE - count) >= PIPELINE_DEPTH, on_off_o[0]);
        end
        check_bit("on_off_wait", 1'b1, out_flit_q.size() == 0);
        release_vc(1);
        compare_outputs("on_off_drain");
        check_bit("on_off_recover", 1'b1, on_off_o[0]);
        release_vc(3);
    endtask

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b1;
        data_i       = '0;
        valid_i      = 1'b0;
        vc_release_i = '0;
        errors       = 0;
        lcg_state    = 32'hf3e7;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        reset_values();
        single_packet();
        route_all_ports();
        interleave_packets();
        on_off_flow();
        $display("Run complete with %0d errors", errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* src.f */
noc_params.sv
mesh_params.sv
circular_buffer.sv
input_buffer.sv
vc_allocator.sv
input_port.sv
router_input_unit.sv
router_input_unit_chk.sv
tb_router_input_unit.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, and decide on the pass line in sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_router_input_unit -f src.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log && echo "simulation passed" || { echo "TEST FAIL"; exit 1; }
